// ==== sources.f ====
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/reg_block.sv
rtl/sequencer.sv
rtl/cpu_core.sv
tb/mem_model.sv
tb/tb_cpu_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cpu_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_cpu_core -o sim_tb_cpu_core

# Exit status is nonzero when the testbench stops on an error
./obj_dir/sim_tb_cpu_core

// ==== tb/tb_cpu_core.sv ====
`timescale 1ns/10ps

module tb_cpu_core;

    import cpu_pkg::*;

    localparam addr_t RESET_PC     = 16'h0040;
    localparam byte_t HL_HI        = 8'h80;
    localparam byte_t HL_LO        = 8'h10;
    localparam int    NUM_CASES    = 18;
    localparam int    NUM_RANDOM   = 40;
    localparam int    HALT_TIMEOUT = 300;

    localparam logic [1:0] FORM_REG = 2'd0;
    localparam logic [1:0] FORM_IMM = 2'd1;
    localparam logic [1:0] FORM_MEM = 2'd2;   // Both operands pass through (HL)

    typedef struct packed {
        alu_op_t    op;
        byte_t      x;
        byte_t      y;
        logic       cin;
        logic [1:0] form;
    } alu_case_t;

    localparam alu_case_t CASES [NUM_CASES] = '{
        '{ALU_ADD, 8'h3A, 8'hC6, 1'b0, FORM_REG},
        '{ALU_ADD, 8'h12, 8'h34, 1'b1, FORM_IMM},
        '{ALU_ADC, 8'hFF, 8'h00, 1'b1, FORM_MEM},
        '{ALU_ADC, 8'h0F, 8'h00, 1'b1, FORM_REG},
        '{ALU_SUB, 8'h10, 8'h01, 1'b0, FORM_REG},
        '{ALU_SUB, 8'h05, 8'h05, 1'b1, FORM_IMM},
        '{ALU_SBC, 8'h00, 8'h00, 1'b1, FORM_REG},
        '{ALU_SBC, 8'h80, 8'h01, 1'b1, FORM_MEM},
        '{ALU_AND, 8'hF0, 8'h0F, 1'b0, FORM_REG},
        '{ALU_AND, 8'h3C, 8'h2A, 1'b1, FORM_IMM},
        '{ALU_XOR, 8'h55, 8'h55, 1'b0, FORM_MEM},
        '{ALU_XOR, 8'hA5, 8'h0F, 1'b1, FORM_REG},
        '{ALU_OR,  8'h00, 8'h00, 1'b1, FORM_IMM},
        '{ALU_OR,  8'h81, 8'h18, 1'b0, FORM_MEM},
        '{ALU_OR,  8'h0C, 8'h30, 1'b1, FORM_REG},
        '{ALU_CP,  8'h42, 8'h42, 1'b0, FORM_REG},
        '{ALU_CP,  8'h10, 8'h20, 1'b0, FORM_IMM},
        '{ALU_CP,  8'h77, 8'h78, 1'b1, FORM_MEM}
    };

    logic  clock;
    logic  rst_n;
    addr_t mem_addr;
    logic  mem_rd;
    logic  mem_wr;
    byte_t mem_wdata;
    byte_t mem_rdata;
    logic  halted;

    logic [31:0] lfsr_state;
    addr_t       prog_pc;
    int          exp_cycles;
    addr_t       exp_addr [$];
    byte_t       exp_data [$];
    addr_t       got_addr [$];
    byte_t       got_data [$];

    cpu_core #(
        .reset_pc(RESET_PC)
    ) u_cpu_core (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_addr  (mem_addr),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    mem_model u_mem_model (
        .clock (clock),
        .rd    (mem_rd),
        .wr    (mem_wr),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    initial
    begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(negedge clock)
    begin
        if (rst_n && mem_wr)
        begin
            got_addr.push_back(mem_addr);   // Captured mid-cycle
            got_data.push_back(mem_wdata);
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "Stopped at first error");
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output byte_t v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
    endtask

    // Returns {Z, N, H, C, result}
    function automatic logic [11:0] alu_model(input alu_op_t op, input byte_t a,
                                              input byte_t b, input logic c);
        int    ci;
        int    full;
        int    half;
        logic  sub;
        logic  logic_op;
        byte_t r;
        logic  hf;
        logic  cf;
        ci       = ((op == ALU_ADC) || (op == ALU_SBC)) ? int'(c) : 0;
        sub      = (op == ALU_SUB) || (op == ALU_SBC) || (op == ALU_CP);
        logic_op = (op == ALU_AND) || (op == ALU_XOR) || (op == ALU_OR);
        if (sub)
        begin
            full = int'(a) - int'(b) - ci;
            half = (int'(a) & 15) - (int'(b) & 15) - ci;
            cf   = (full < 0);
            hf   = (half < 0);
        end
        else
        begin
            full = int'(a) + int'(b) + ci;
            half = (int'(a) & 15) + (int'(b) & 15) + ci;
            cf   = (full > 255);
            hf   = (half > 15);
        end
        case (op)
            ALU_AND: r = a & b;
            ALU_XOR: r = a ^ b;
            ALU_OR:  r = a | b;
            default: r = 8'(full);
        endcase
        if (logic_op)
        begin
            hf = (op == ALU_AND);
            cf = 1'b0;
        end
        return {(r == 8'd0), sub, hf, cf, r};
    endfunction

    task automatic put_byte(input byte_t b);
        u_mem_model.write_byte(prog_pc, b);
        prog_pc = prog_pc + 16'd1;
    endtask

    task automatic put_addr(input byte_t opcode, input addr_t target);
        put_byte(opcode);
        put_byte(target[7:0]);   // Low byte first
        put_byte(target[15:8]);
    endtask

    // JP cc over a store of mark_skip, landing on a store of mark_taken
    task automatic put_branch(input byte_t jp_op, input logic taken,
                              input byte_t mark_taken, input byte_t mark_skip);
        addr_t p0;
        p0 = prog_pc;
        put_addr(jp_op, p0 + 16'd8);
        put_byte(8'h36);
        put_byte(mark_skip);
        put_addr(OP_JP, p0 + 16'd10);
        put_byte(8'h36);
        put_byte(mark_taken);
        exp_cycles += taken ? 7 : 11;
        exp_addr.push_back({HL_HI, HL_LO});
        exp_data.push_back(taken ? mark_taken : mark_skip);
    endtask

    task automatic build_program(input alu_case_t tc, output logic [11:0] model);
        model      = alu_model(tc.op, tc.x, tc.y, tc.cin);
        prog_pc    = RESET_PC;
        exp_cycles = 0;
        exp_addr.delete();
        exp_data.delete();
        put_byte(8'h26);                       // LD H,n
        put_byte(HL_HI);
        put_byte(8'h2E);                       // LD L,n
        put_byte(HL_LO);
        put_byte(8'h3E);                       // LD A,n then ADD A,n sets C
        put_byte(tc.cin ? 8'hFF : 8'h00);
        put_byte(8'hC6);
        put_byte(tc.cin ? 8'h01 : 8'h00);
        put_byte(8'h0E);                       // LD C,x
        put_byte(tc.x);
        put_byte(8'h06);                       // LD B,y
        put_byte(tc.y);
        exp_cycles += 18;
        case (tc.form)
            FORM_IMM:
            begin
                put_byte(8'h79);               // LD A,C
                put_byte({2'b11, tc.op, 3'b110});
                put_byte(tc.y);
                exp_cycles += 5;
            end
            FORM_MEM:
            begin
                put_byte(8'h71);               // LD (HL),C
                put_byte(8'h7E);               // LD A,(HL)
                put_byte(8'h70);               // LD (HL),B
                put_byte({2'b10, tc.op, 3'b110});
                exp_cycles += 10;
                exp_addr.push_back({HL_HI, HL_LO});
                exp_data.push_back(tc.x);
                exp_addr.push_back({HL_HI, HL_LO});
                exp_data.push_back(tc.y);
            end
            default:
            begin
                put_byte(8'h79);
                put_byte({2'b10, tc.op, 3'b000});
                exp_cycles += 4;
            end
        endcase
        put_byte(8'h77);                       // LD (HL),A
        exp_cycles += 2;
        exp_addr.push_back({HL_HI, HL_LO});
        exp_data.push_back((tc.op == ALU_CP) ? tc.x : model[7:0]);
        put_branch(8'hCA, model[8 + FLAG_Z], 8'hA5, 8'h5A);   // JP Z
        put_branch(8'hDA, model[8 + FLAG_C], 8'hC6, 8'h6C);   // JP C
        put_byte(OP_HALT);
    endtask

    task automatic run_case(input alu_case_t tc);
        logic [11:0] model;
        int          n;
        logic        done;
        @(posedge clock);
        #1;
        rst_n = 1'b0;
        got_addr.delete();
        got_data.delete();
        build_program(tc, model);
        for (int i = 0; i < 10; i++)
        begin
            @(negedge clock);
            check_value("mem_rd in reset", 32'(mem_rd), 32'd0);
            check_value("mem_wr in reset", 32'(mem_wr), 32'd0);
            check_value("halted in reset", 32'(halted), 32'd0);
            @(posedge clock);
            #1;
        end
        rst_n = 1'b1;
        n     = 0;
        done  = 1'b0;
        while (!done)
        begin
            @(posedge clock);
            #1;
            n++;
            if (n == 1)
            begin
                check_value("mem_rd first fetch", 32'(mem_rd), 32'd1);
                check_value("mem_addr first fetch", 32'(mem_addr), 32'(RESET_PC));
            end
            if (halted)
            begin
                done = 1'b1;
            end
            else if (n >= HALT_TIMEOUT)
            begin
                $display("Timeout: halted did not rise within %0d cycles", HALT_TIMEOUT);
                $display("TESTBENCH FAILED");
                $fatal(1, "Stopped on timeout");
            end
        end
        // Idle cycle after reset plus the HALT fetch
        check_value("cycles to halted", n, exp_cycles + 2);
        repeat (20)
        begin
            @(negedge clock);
            check_value("mem_rd after halt", 32'(mem_rd), 32'd0);
            check_value("mem_wr after halt", 32'(mem_wr), 32'd0);
            check_value("halted", 32'(halted), 32'd1);
        end
        check_value("write count", got_addr.size(), exp_addr.size());
        for (int i = 0; i < exp_addr.size(); i++)
        begin
            check_value("write address", 32'(got_addr[i]), 32'(exp_addr[i]));
            check_value("write data", 32'(got_data[i]), 32'(exp_data[i]));
        end
        check_value("flags", 32'(u_cpu_core.flags), 32'(model[11:8]));
    endtask

    initial
    begin
        alu_case_t tc;
        byte_t     v;
        rst_n      = 1'b0;
        lfsr_state = 32'h946b249e;
        for (int i = 0; i < NUM_CASES; i++)
        begin
            run_case(CASES[i]);
        end
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            take_bits(3, v);
            tc.op = v[2:0];
            take_bits(8, v);
            tc.x = v;
            take_bits(8, v);
            tc.y = v;
            take_bits(1, v);
            tc.cin = v[0];
            take_bits(2, v);
            tc.form = (v[1:0] == 2'd3) ? FORM_REG : v[1:0];
            run_case(tc);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== tb/mem_model.sv ====
`timescale 1ns/10ps

module mem_model (
    input  logic           clock,
    input  logic           rd,
    input  logic           wr,
    input  cpu_pkg::addr_t addr,
    input  cpu_pkg::byte_t wdata,
    output cpu_pkg::byte_t rdata
);

    import cpu_pkg::*;

    byte_t mem [65536];

    initial
    begin
        for (int i = 0; i < 65536; i++)
        begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h3C;   // Pattern over the whole address
        end
    end

    task write_byte(input addr_t a, input byte_t d);
        mem[a] = d;
    endtask

    always @(posedge clock)
    begin
        if (wr)
        begin
            mem[addr] = wdata;
        end
        if (rd)
        begin
            rdata <= mem[addr];   // Visible during the next cycle
        end
    end

endmodule

// ==== rtl/cpu_core.sv ====
`timescale 1ns/10ps

module cpu_core #(
    parameter cpu_pkg::addr_t reset_pc = '0
) (
    input  logic           clock,
    input  logic           rst_n,
    output cpu_pkg::addr_t mem_addr,
    output logic           mem_rd,
    output logic           mem_wr,
    output cpu_pkg::byte_t mem_wdata,
    input  cpu_pkg::byte_t mem_rdata,
    output logic           halted
);

    import cpu_pkg::*;

    reg_idx_t rd_sel_a;
    reg_idx_t rd_sel_b;
    logic     wr_en;
    reg_idx_t wr_sel;
    byte_t    wr_data;
    logic     flags_wr;
    flags_t   flags_next;
    byte_t    rd_data_a;
    byte_t    rd_data_b;
    addr_t    hl;
    flags_t   flags;
    alu_op_t  alu_op;
    byte_t    alu_operand_b;
    byte_t    alu_result;
    flags_t   alu_flags;

    sequencer #(
        .reset_pc(reset_pc)
    ) u_sequencer (
        .clock         (clock),
        .rst_n         (rst_n),
        .mem_addr      (mem_addr),
        .mem_rd        (mem_rd),
        .mem_wr        (mem_wr),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata),
        .halted        (halted),
        .rd_sel_a      (rd_sel_a),
        .rd_sel_b      (rd_sel_b),
        .wr_en         (wr_en),
        .wr_sel        (wr_sel),
        .wr_data       (wr_data),
        .flags_wr      (flags_wr),
        .flags_next    (flags_next),
        .rd_data_a     (rd_data_a),
        .rd_data_b     (rd_data_b),
        .hl            (hl),
        .flags         (flags),
        .alu_op        (alu_op),
        .alu_operand_b (alu_operand_b),
        .alu_result    (alu_result),
        .alu_flags     (alu_flags)
    );

    reg_block u_reg_block (
        .clock      (clock),
        .rst_n      (rst_n),
        .rd_sel_a   (rd_sel_a),
        .rd_sel_b   (rd_sel_b),
        .wr_en      (wr_en),
        .wr_sel     (wr_sel),
        .wr_data    (wr_data),
        .flags_wr   (flags_wr),
        .flags_next (flags_next),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .hl         (hl),
        .flags      (flags)
    );

    alu u_alu (
        .op        (alu_op),
        .operand_a (rd_data_a),
        .operand_b (alu_operand_b),
        .carry_in  (flags[FLAG_C]),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

endmodule

// ==== rtl/sequencer.sv ====
`timescale 1ns/10ps

module sequencer #(
    parameter cpu_pkg::addr_t reset_pc = '0
) (
    input  logic             clock,
    input  logic             rst_n,
    output cpu_pkg::addr_t   mem_addr,
    output logic             mem_rd,
    output logic             mem_wr,
    output cpu_pkg::byte_t   mem_wdata,
    input  cpu_pkg::byte_t   mem_rdata,
    output logic             halted,
    output cpu_pkg::reg_idx_t rd_sel_a,
    output cpu_pkg::reg_idx_t rd_sel_b,
    output logic             wr_en,
    output cpu_pkg::reg_idx_t wr_sel,
    output cpu_pkg::byte_t   wr_data,
    output logic             flags_wr,
    output cpu_pkg::flags_t  flags_next,
    input  cpu_pkg::byte_t   rd_data_a,
    input  cpu_pkg::byte_t   rd_data_b,
    input  cpu_pkg::addr_t   hl,
    input  cpu_pkg::flags_t  flags,
    output cpu_pkg::alu_op_t alu_op,
    output cpu_pkg::byte_t   alu_operand_b,
    input  cpu_pkg::byte_t   alu_result,
    input  cpu_pkg::flags_t  alu_flags
);

    import cpu_pkg::*;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_OPERAND,
        ST_ADDR_LO,
        ST_ADDR_HI,
        ST_HALTED
    } state_t;

    state_t   state;
    state_t   next_state;
    addr_t    pc_q;
    addr_t    pc_next;
    byte_t    inst_q;
    byte_t    addr_lo_q;
    logic     halt_q;
    logic     halt_next;

    byte_t    op;
    reg_idx_t dst;
    reg_idx_t src;
    logic     is_halt;
    logic     is_ld_rr;
    logic     is_ld_rn;
    logic     is_alu_r;
    logic     is_alu_n;
    logic     is_jp_cc;
    logic     cond_met;
    logic     jp_taken;
    logic     addr_sel_hl;
    logic     alu_store;

    // Opcode sits on the bus during decode, in the buffer afterwards
    assign op  = (state == ST_DECODE) ? mem_rdata : inst_q;
    assign dst = op[5:3];
    assign src = op[2:0];

    assign is_halt  = (op == OP_HALT);
    assign is_ld_rr = (op[7:6] == 2'b01) && !is_halt;
    assign is_ld_rn = (op[7:6] == 2'b00) && (src == 3'b110);
    assign is_alu_r = (op[7:6] == 2'b10);
    assign is_alu_n = (op[7:6] == 2'b11) && (src == 3'b110);
    assign is_jp_cc = (op[7:5] == 3'b110) && (src == 3'b010);

    always_comb
    begin
        case (op[4:3])
            2'b00:   cond_met = !flags[FLAG_Z];  // NZ
            2'b01:   cond_met = flags[FLAG_Z];
            2'b10:   cond_met = !flags[FLAG_C];  // NC
            default: cond_met = flags[FLAG_C];
        endcase
    end

    assign jp_taken = (op == OP_JP) || (is_jp_cc && cond_met);

    assign alu_op     = op[5:3];
    assign rd_sel_a   = (is_alu_r || is_alu_n) ? REG_A : src;
    assign rd_sel_b   = src;
    assign flags_next = alu_flags;
    assign mem_addr   = addr_sel_hl ? hl : pc_q;
    assign halted     = halt_q || ((state == ST_DECODE) && is_halt);

    always_comb
    begin
        next_state    = state;
        pc_next       = pc_q;
        halt_next     = halt_q;
        mem_rd        = 1'b0;
        mem_wr        = 1'b0;
        mem_wdata     = rd_data_a;
        addr_sel_hl   = 1'b0;
        wr_en         = 1'b0;
        wr_sel        = dst;
        wr_data       = rd_data_a;
        flags_wr      = 1'b0;
        alu_operand_b = rd_data_b;
        alu_store     = 1'b0;

        case (state)
            ST_FETCH:
            begin
                mem_rd     = 1'b1;
                pc_next    = pc_q + 16'd1;
                next_state = ST_DECODE;
            end
            ST_DECODE:
            begin
                next_state = ST_FETCH;
                if (is_halt)
                begin
                    halt_next  = 1'b1;
                    next_state = ST_HALTED;
                end
                else if ((is_ld_rr || is_alu_r) && (src == REG_MEM))
                begin
                    mem_rd      = 1'b1;          // Source byte at H:L
                    addr_sel_hl = 1'b1;
                    next_state  = ST_OPERAND;
                end
                else if (is_ld_rr && (dst == REG_MEM))
                begin
                    mem_wr      = 1'b1;
                    addr_sel_hl = 1'b1;
                end
                else if (is_ld_rr)
                begin
                    wr_en = 1'b1;
                end
                else if (is_alu_r)
                begin
                    alu_store = 1'b1;
                end
                else if (is_ld_rn || is_alu_n)
                begin
                    mem_rd     = 1'b1;           // Immediate byte
                    pc_next    = pc_q + 16'd1;
                    next_state = ST_OPERAND;
                end
                else if ((op == OP_JP) || is_jp_cc)
                begin
                    mem_rd     = 1'b1;
                    pc_next    = pc_q + 16'd1;
                    next_state = ST_ADDR_LO;
                end
            end
            ST_OPERAND:
            begin
                next_state = ST_FETCH;
                if (is_ld_rn && (dst == REG_MEM))
                begin
                    mem_wr      = 1'b1;
                    addr_sel_hl = 1'b1;
                    mem_wdata   = mem_rdata;
                end
                else if (is_ld_rr || is_ld_rn)
                begin
                    wr_en   = 1'b1;
                    wr_data = mem_rdata;
                end
                else
                begin
                    alu_operand_b = mem_rdata;
                    alu_store     = 1'b1;
                end
            end
            ST_ADDR_LO:
            begin
                mem_rd     = 1'b1;               // High address byte
                pc_next    = pc_q + 16'd1;
                next_state = ST_ADDR_HI;
            end
            ST_ADDR_HI:
            begin
                next_state = ST_FETCH;
                if (jp_taken)
                begin
                    pc_next = {mem_rdata, addr_lo_q};
                end
            end
            default:
            begin
                // Leaves only once, on the first edge after reset
                if (!halt_q)
                begin
                    next_state = ST_FETCH;
                end
            end
        endcase

        if (alu_store)
        begin
            flags_wr = 1'b1;
            wr_en    = (alu_op != ALU_CP);   // CP keeps A
            wr_sel   = REG_A;
            wr_data  = alu_result;
        end
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state  <= ST_HALTED;
            pc_q   <= reset_pc;
            inst_q <= '0;
            halt_q <= 1'b0;
        end
        else
        begin
            state  <= next_state;
            pc_q   <= pc_next;
            halt_q <= halt_next;
            if (state == ST_DECODE)
            begin
                inst_q <= mem_rdata;
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (state == ST_ADDR_LO)
        begin
            addr_lo_q <= mem_rdata;          // Low byte comes first
        end
    end

endmodule

// ==== rtl/reg_block.sv ====
`timescale 1ns/10ps

module reg_block (
    input  logic              clock,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t rd_sel_a,
    input  cpu_pkg::reg_idx_t rd_sel_b,
    input  logic              wr_en,
    input  cpu_pkg::reg_idx_t wr_sel,
    input  cpu_pkg::byte_t    wr_data,
    input  logic              flags_wr,
    input  cpu_pkg::flags_t   flags_next,
    output cpu_pkg::byte_t    rd_data_a,
    output cpu_pkg::byte_t    rd_data_b,
    output cpu_pkg::addr_t    hl,
    output cpu_pkg::flags_t   flags
);

    import cpu_pkg::*;

    byte_t regs [7];

    // A lives in slot 6 since index 6 is the memory operand
    function automatic logic [2:0] reg_slot(input reg_idx_t sel);
        return (sel == REG_A) ? 3'd6 : sel;
    endfunction

    assign rd_data_a = (rd_sel_a == REG_MEM) ? '0 : regs[reg_slot(rd_sel_a)];
    assign rd_data_b = (rd_sel_b == REG_MEM) ? '0 : regs[reg_slot(rd_sel_b)];
    assign hl        = {regs[REG_H], regs[REG_L]};

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 7; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && (wr_sel != REG_MEM))
        begin
            regs[reg_slot(wr_sel)] <= wr_data;
        end
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            flags <= FLAGS_RESET;
        end
        else if (flags_wr)
        begin
            flags <= flags_next;
        end
    end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  cpu_pkg::alu_op_t op,
    input  cpu_pkg::byte_t   operand_a,
    input  cpu_pkg::byte_t   operand_b,
    input  logic             carry_in,
    output cpu_pkg::byte_t   result,
    output cpu_pkg::flags_t  flags_out
);

    import cpu_pkg::*;

    logic       cin;
    logic       is_sub;
    logic       is_arith;
    logic [8:0] full;   // Bit 8 is carry or borrow out
    logic [4:0] half;   // Bit 4 is carry or borrow out of bit 3

    assign cin      = ((op == ALU_ADC) || (op == ALU_SBC)) ? carry_in : 1'b0;
    assign is_sub   = (op == ALU_SUB) || (op == ALU_SBC) || (op == ALU_CP);
    assign is_arith = is_sub || (op == ALU_ADD) || (op == ALU_ADC);

    always_comb
    begin
        if (is_sub)
        begin
            full = {1'b0, operand_a} - {1'b0, operand_b} - {8'd0, cin};
            half = {1'b0, operand_a[3:0]} - {1'b0, operand_b[3:0]} - {4'd0, cin};
        end
        else
        begin
            full = {1'b0, operand_a} + {1'b0, operand_b} + {8'd0, cin};
            half = {1'b0, operand_a[3:0]} + {1'b0, operand_b[3:0]} + {4'd0, cin};
        end
    end

    always_comb
    begin
        case (op)
            ALU_AND: result = operand_a & operand_b;
            ALU_XOR: result = operand_a ^ operand_b;
            ALU_OR:  result = operand_a | operand_b;
            default: result = full[7:0];  // CP result is dropped by the sequencer
        endcase
    end

    always_comb
    begin
        flags_out[FLAG_Z] = (result == 8'd0);
        flags_out[FLAG_N] = is_sub;
        flags_out[FLAG_H] = is_arith ? half[4] : (op == ALU_AND);
        flags_out[FLAG_C] = is_arith ? full[8] : 1'b0;
    end

endmodule

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [2:0]  alu_op_t;
    typedef logic [3:0]  flags_t;   // Z N H C from the top bit

    // Register field encoding of the instruction
    localparam reg_idx_t REG_B   = 3'd0;
    localparam reg_idx_t REG_C   = 3'd1;
    localparam reg_idx_t REG_D   = 3'd2;
    localparam reg_idx_t REG_E   = 3'd3;
    localparam reg_idx_t REG_H   = 3'd4;
    localparam reg_idx_t REG_L   = 3'd5;
    localparam reg_idx_t REG_MEM = 3'd6;  // Memory at H:L
    localparam reg_idx_t REG_A   = 3'd7;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_ADC = 3'd1;
    localparam alu_op_t ALU_SUB = 3'd2;
    localparam alu_op_t ALU_SBC = 3'd3;
    localparam alu_op_t ALU_AND = 3'd4;
    localparam alu_op_t ALU_XOR = 3'd5;
    localparam alu_op_t ALU_OR  = 3'd6;
    localparam alu_op_t ALU_CP  = 3'd7;

    // Bit positions inside flags_t
    localparam int FLAG_Z = 3;
    localparam int FLAG_N = 2;
    localparam int FLAG_H = 1;
    localparam int FLAG_C = 0;

    localparam byte_t OP_HALT = 8'h76;
    localparam byte_t OP_JP   = 8'hC3;

    localparam flags_t FLAGS_RESET = 4'b1000;  // Z set

endpackage
